// ==== design/mem_req_pkg.sv ====
package mem_req_pkg;

   localparam int ADDR_WIDTH    = 6;
   localparam int DATA_WIDTH    = 32;
   localparam int INDEX_WIDTH   = 3;
   localparam int MEM_WORDS     = 64;
   localparam int QUEUE_ENTRIES = 8;  // Command ring depth
   localparam int DATA_ENTRIES  = 4;  // Write-data ring depth
   localparam int CNT_WIDTH     = 16;

   // Configuration register map
   localparam logic [1:0] CFG_CTRL   = 2'd0;
   localparam logic [1:0] CFG_WR_CNT = 2'd1;
   localparam logic [1:0] CFG_RD_CNT = 2'd2;

   typedef enum logic {
      read,
      write
   } r_type;

   typedef logic [ADDR_WIDTH-1:0]  address_type;
   typedef logic [DATA_WIDTH-1:0]  data_type;
   typedef logic [INDEX_WIDTH-1:0] index_type;

   typedef struct packed {
      r_type       req_type;
      address_type address;
      data_type    data;     // Only meaningful for writes
   } request;

endpackage

// ==== design/req_queue_if.sv ====
interface req_queue_if import mem_req_pkg::*; ();

   request    req;
   index_type index;
   logic      valid;
   logic      grant;  // Transfer when valid and grant both high

   modport queue_mp (
      output req,
      output index,
      output valid,
      input  grant
   );

   modport engine_mp (
      input  req,
      input  index,
      input  valid,
      output grant
   );

endinterface

// ==== design/mem_req_queue.sv ====
module mem_req_queue import mem_req_pkg::*; #(
   parameter int entries_no      = QUEUE_ENTRIES,
   parameter int data_entries_no = DATA_ENTRIES
) (
   input  logic              clk,
   input  logic              rst_n,
   input  request            request_i,
   input  index_type         index_i,
   input  logic              valid_i,
   output logic              grant_o,
   req_queue_if.queue_mp     q
);

   localparam int CMD_PTR_W  = $clog2(entries_no);
   localparam int DATA_PTR_W = $clog2(data_entries_no);
   localparam int CMD_CNT_W  = $clog2(entries_no + 1);
   localparam int DATA_CNT_W = $clog2(data_entries_no + 1);

   typedef struct packed {
      r_type       req_type;
      address_type address;
      index_type   index;
   } cmd_t;

   typedef enum logic [1:0] {
      EMPTY,
      MIDDLE,
      FULL
   } state_t;

   state_t cs, ns;

   logic [CMD_PTR_W-1:0]  cmd_push_ptr, cmd_push_ptr_ns;
   logic [CMD_PTR_W-1:0]  cmd_pop_ptr, cmd_pop_ptr_ns;
   logic [DATA_PTR_W-1:0] data_push_ptr, data_push_ptr_ns;
   logic [DATA_PTR_W-1:0] data_pop_ptr, data_pop_ptr_ns;
   logic [CMD_CNT_W-1:0]  cmd_cnt, cmd_cnt_ns;
   logic [DATA_CNT_W-1:0] wr_cnt, wr_cnt_ns;  // Unpopped writes

   cmd_t     cmd_ring [entries_no];
   data_type data_ring [data_entries_no];
   cmd_t     head;

   logic push, pop;
   logic push_wr, pop_wr;

   assign head    = cmd_ring[cmd_pop_ptr];
   assign push    = valid_i && grant_o;
   assign pop     = q.valid && q.grant;
   assign push_wr = push && (request_i.req_type == write);
   assign pop_wr  = pop && (head.req_type == write);

   // Handshake levels follow the state only
   always_comb begin
      grant_o = 1'b0;
      q.valid = 1'b0;
      case (cs)
         EMPTY: grant_o = 1'b1;
         MIDDLE: begin
            grant_o = 1'b1;
            q.valid = 1'b1;
         end
         FULL: q.valid = 1'b1;  // Pop always allowed here
         default: ;
      endcase
   end

   always_comb begin
      cmd_push_ptr_ns  = cmd_push_ptr;
      cmd_pop_ptr_ns   = cmd_pop_ptr;
      data_push_ptr_ns = data_push_ptr;
      data_pop_ptr_ns  = data_pop_ptr;

      if (push)
         cmd_push_ptr_ns = (cmd_push_ptr == entries_no - 1) ? '0 : cmd_push_ptr + 1'b1;
      if (pop)
         cmd_pop_ptr_ns = (cmd_pop_ptr == entries_no - 1) ? '0 : cmd_pop_ptr + 1'b1;
      // Data ring moves only for writes
      if (push_wr)
         data_push_ptr_ns = (data_push_ptr == data_entries_no - 1) ? '0 : data_push_ptr + 1'b1;
      if (pop_wr)
         data_pop_ptr_ns = (data_pop_ptr == data_entries_no - 1) ? '0 : data_pop_ptr + 1'b1;
   end

   always_comb begin
      case ({push, pop})
         2'b10:   cmd_cnt_ns = cmd_cnt + 1'b1;
         2'b01:   cmd_cnt_ns = cmd_cnt - 1'b1;
         default: cmd_cnt_ns = cmd_cnt;
      endcase
      case ({push_wr, pop_wr})
         2'b10:   wr_cnt_ns = wr_cnt + 1'b1;
         2'b01:   wr_cnt_ns = wr_cnt - 1'b1;
         default: wr_cnt_ns = wr_cnt;
      endcase

      // Either ring filling up stops the push side
      if (cmd_cnt_ns == 0)
         ns = EMPTY;
      else if ((cmd_cnt_ns == entries_no) || (wr_cnt_ns == data_entries_no))
         ns = FULL;
      else
         ns = MIDDLE;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cs            <= EMPTY;
         cmd_push_ptr  <= '0;
         cmd_pop_ptr   <= '0;
         data_push_ptr <= '0;
         data_pop_ptr  <= '0;
         cmd_cnt       <= '0;
         wr_cnt        <= '0;
      end else begin
         cs            <= ns;
         cmd_push_ptr  <= cmd_push_ptr_ns;
         cmd_pop_ptr   <= cmd_pop_ptr_ns;
         data_push_ptr <= data_push_ptr_ns;
         data_pop_ptr  <= data_pop_ptr_ns;
         cmd_cnt       <= cmd_cnt_ns;
         wr_cnt        <= wr_cnt_ns;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         cmd_ring[cmd_push_ptr] <= '{request_i.req_type, request_i.address, index_i};
      end
      if (push_wr) begin
         data_ring[data_push_ptr] <= request_i.data;
      end
   end

   assign q.req   = '{head.req_type, head.address, data_ring[data_pop_ptr]};
   assign q.index = head.index;

endmodule

// ==== design/mem_engine.sv ====
module mem_engine import mem_req_pkg::*; (
   input  logic           clk,
   input  logic           rst_n,
   req_queue_if.engine_mp q,
   input  logic           engine_en_i,
   output logic           rsp_valid_o,
   output index_type      rsp_index_o,
   output data_type       rsp_data_o,
   output logic           served_wr_o,
   output logic           served_rd_o
);

   data_type mem [MEM_WORDS];

   logic      pop;
   logic      wr_pop;
   logic      rd_pop;
   logic      rd_pend;  // Read popped at the last edge
   index_type rd_index;
   data_type  rd_data;

   assign q.grant = engine_en_i;
   assign pop     = q.valid && q.grant;
   assign wr_pop  = pop && (q.req.req_type == write);
   assign rd_pop  = pop && (q.req.req_type == read);

   // Write lands at the pop edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_pop) begin
         mem[q.req.address] <= q.req.data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend     <= 1'b0;
         rsp_valid_o <= 1'b0;
         served_wr_o <= 1'b0;
      end else begin
         rd_pend     <= rd_pop;
         rsp_valid_o <= rd_pend;  // One-cycle pulse
         served_wr_o <= wr_pop;
      end
   end

   // Word as it was at the pop edge
   always_ff @(posedge clk) begin
      if (rd_pop) begin
         rd_index <= q.index;
         rd_data  <= mem[q.req.address];
      end
      if (rd_pend) begin
         rsp_index_o <= rd_index;
         rsp_data_o  <= rd_data;
      end
   end

   // A read is served when its response goes out
   assign served_rd_o = rsp_valid_o;

endmodule

// ==== design/mem_cfg_regs.sv ====
module mem_cfg_regs import mem_req_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       cfg_we_i,
   input  logic [1:0] cfg_addr_i,
   input  data_type   cfg_wdata_i,
   output data_type   cfg_rdata_o,
   input  logic       served_wr_i,
   input  logic       served_rd_i,
   output logic       engine_en_o
);

   logic [CNT_WIDTH-1:0] wr_cnt;
   logic [CNT_WIDTH-1:0] rd_cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         engine_en_o <= 1'b0;
         wr_cnt      <= '0;
         rd_cnt      <= '0;
      end else begin
         if (cfg_we_i && cfg_addr_i == CFG_CTRL)
            engine_en_o <= cfg_wdata_i[0];

         if (cfg_we_i && cfg_addr_i == CFG_WR_CNT)
            wr_cnt <= '0;  // Clear beats increment
         else if (served_wr_i)
            wr_cnt <= wr_cnt + 1'b1;

         if (cfg_we_i && cfg_addr_i == CFG_RD_CNT)
            rd_cnt <= '0;
         else if (served_rd_i)
            rd_cnt <= rd_cnt + 1'b1;
      end
   end

   always_comb begin
      cfg_rdata_o = '0;
      case (cfg_addr_i)
         CFG_CTRL:   cfg_rdata_o[0] = engine_en_o;
         CFG_WR_CNT: cfg_rdata_o[CNT_WIDTH-1:0] = wr_cnt;
         CFG_RD_CNT: cfg_rdata_o[CNT_WIDTH-1:0] = rd_cnt;
         default: ;  // Unmapped reads as zero
      endcase
   end

endmodule

// ==== design/mem_req_top.sv ====
module mem_req_top import mem_req_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req_valid_i,
   input  r_type       req_type_i,
   input  address_type req_addr_i,
   input  data_type    req_data_i,
   input  index_type   req_index_i,
   output logic        req_ready_o,
   output logic        rsp_valid_o,
   output index_type   rsp_index_o,
   output data_type    rsp_data_o,
   input  logic        cfg_we_i,
   input  logic [1:0]  cfg_addr_i,
   input  data_type    cfg_wdata_i,
   output data_type    cfg_rdata_o
);

   request req;
   logic   engine_en;
   logic   served_wr;
   logic   served_rd;

   req_queue_if rq ();

   assign req = '{req_type: req_type_i, address: req_addr_i, data: req_data_i};

   mem_req_queue #(
      .entries_no      (QUEUE_ENTRIES),
      .data_entries_no (DATA_ENTRIES)
   ) u_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .request_i (req),
      .index_i   (req_index_i),
      .valid_i   (req_valid_i),
      .grant_o   (req_ready_o),
      .q         (rq.queue_mp)
   );

   mem_engine u_engine (
      .clk         (clk),
      .rst_n       (rst_n),
      .q           (rq.engine_mp),
      .engine_en_i (engine_en),
      .rsp_valid_o (rsp_valid_o),
      .rsp_index_o (rsp_index_o),
      .rsp_data_o  (rsp_data_o),
      .served_wr_o (served_wr),
      .served_rd_o (served_rd)
   );

   mem_cfg_regs u_cfg (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .served_wr_i (served_wr),
      .served_rd_i (served_rd),
      .engine_en_o (engine_en)
   );

endmodule

// ==== tests/mem_req_tb.sv ====
module mem_req_tb import mem_req_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RAND_OPS    = 200;
   localparam int PUSH_WAIT   = 64;
   localparam int DRAIN_WAIT  = 200;
   localparam int TEST_CYCLES = 16 + 60 + 60 + 80 + 80 + RAND_OPS * 10 + 60;
   localparam int WATCHDOG_NS = TEST_CYCLES * 4 + 2000;

   typedef struct {
      index_type idx;
      data_type  data;
   } exp_rsp_t;

   logic clk, rst_n;
   logic req_valid_i, req_ready_o;
   r_type req_type_i;
   address_type req_addr_i;
   data_type req_data_i, rsp_data_o, cfg_wdata_i, cfg_rdata_o;
   index_type req_index_i, rsp_index_o;
   logic rsp_valid_o, cfg_we_i;
   logic [1:0] cfg_addr_i;

   exp_rsp_t exp_q[$];
   data_type model_mem [MEM_WORDS];
   logic exp_avail, en_level;
   index_type exp_index;
   data_type exp_data;
   logic [31:0] rng_state = 32'hde55;
   int err_cnt, test_cnt, fail_cnt, rsp_cnt, wr_pushed, rd_pushed;

   mem_req_top UUT (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   task automatic refresh_head();
      exp_avail = (exp_q.size() != 0);
      if (exp_avail) begin
         exp_index = exp_q[0].idx;
         exp_data  = exp_q[0].data;
      end
   endtask

   // Retire the oldest expected read on each response
   always @(posedge clk) begin
      if (rst_n && rsp_valid_o) begin
         rsp_cnt++;
         if (exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) rsp_valid_o |-> exp_avail)
      else begin
         $display("Response arrived with no read outstanding");
         err_cnt++;
      end
   assert property (@(posedge clk) disable iff (!rst_n)
                    rsp_valid_o && exp_avail |-> rsp_index_o == exp_index)
      else begin
         $display("[ERROR] rsp_index_o expected %h got %h", $sampled(exp_index),
                  $sampled(rsp_index_o));
         err_cnt++;
      end
   assert property (@(posedge clk) disable iff (!rst_n)
                    rsp_valid_o && exp_avail |-> rsp_data_o == exp_data)
      else begin
         $display("[ERROR] rsp_data_o expected %h got %h", $sampled(exp_data),
                  $sampled(rsp_data_o));
         err_cnt++;
      end
   assert property (@(posedge clk) disable iff (!rst_n) rsp_valid_o |-> $past(en_level, 2))
      else begin
         $display("Response arrived for a read popped while the engine was disabled");
         err_cnt++;
      end

   task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp == act)
      else begin
         $display("[ERROR] %s expected %h got %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic cfg_write(input logic [1:0] addr, input data_type val);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = val;
      @(posedge clk);
      @(negedge clk);
      cfg_we_i = 1'b0;
      if (addr == CFG_CTRL)
         en_level = val[0];  // Engine follows from this edge on
   endtask

   task automatic check_reg(input string name, input logic [1:0] addr, input data_type exp);
      cfg_addr_i = addr;
      #1;  // Read port is combinational
      check_equal(name, exp, cfg_rdata_o);
      @(negedge clk);
   endtask

   task automatic push_req(input r_type kind, input address_type addr, input data_type data,
                           input index_type idx);
      int waited;
      exp_rsp_t e;
      waited      = 0;
      req_valid_i = 1'b1;
      req_type_i  = kind;
      req_addr_i  = addr;
      req_data_i  = data;
      req_index_i = idx;
      while (!req_ready_o && waited < PUSH_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (!req_ready_o) begin
         $display("Push with index %0d was never accepted", idx);
         err_cnt++;
         req_valid_i = 1'b0;
         return;
      end
      if (kind == write) begin
         model_mem[addr] = data;
         wr_pushed++;
      end else begin
         e.idx  = idx;
         e.data = model_mem[addr];  // In-order service sees all earlier writes
         exp_q.push_back(e);
         rd_pushed++;
         refresh_head();
      end
      @(posedge clk);
      @(negedge clk);
      req_valid_i = 1'b0;
   endtask

   // Outstanding reads first, then room for queued writes
   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d read responses never arrived", exp_q.size());
         err_cnt++;
      end
      repeat (QUEUE_ENTRIES + 2) @(negedge clk);
   endtask

   task automatic end_test(input string name, input int err_start);
      test_cnt++;
      if (err_cnt == err_start) begin
         $display("Test %0d %s: ok", test_cnt, name);
      end else begin
         fail_cnt++;
         $display("Test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_start);
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      int e0, r0;
      logic [31:0] r;
      address_type a;
      rst_n = 1'b0;
      req_valid_i = 1'b0;
      req_type_i = read;
      req_addr_i = '0;
      req_data_i = '0;
      req_index_i = '0;
      cfg_we_i = 1'b0;
      cfg_addr_i = '0;
      cfg_wdata_i = '0;
      en_level = 1'b0;
      exp_avail = 1'b0;
      exp_index = '0;
      exp_data = '0;
      for (int i = 0; i < MEM_WORDS; i++)
         model_mem[i] = '0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      e0 = err_cnt;
      check_equal("req_ready_o", 1, req_ready_o);
      check_reg("cfg_ctrl", CFG_CTRL, 0);
      check_reg("cfg_wr_cnt", CFG_WR_CNT, 0);
      check_reg("cfg_rd_cnt", CFG_RD_CNT, 0);
      repeat (10) begin
         check_equal("rsp_valid_o", 0, rsp_valid_o);
         @(negedge clk);
      end
      end_test("reset state", e0);

      e0 = err_cnt;
      r0 = rsp_cnt;
      cfg_write(CFG_CTRL, 1);
      push_req(write, 6'd5, 32'hcafe_0005, 3'd0);
      drain();
      push_req(read, 6'd5, '0, 3'd6);
      check_equal("rsp_valid_o", 0, rsp_valid_o);  // Only the push edge so far
      @(negedge clk);
      check_equal("rsp_valid_o", 0, rsp_valid_o);  // Pop edge just passed
      @(negedge clk);
      check_equal("rsp_valid_o", 1, rsp_valid_o);
      drain();
      check_equal("response count", 1, rsp_cnt - r0);
      end_test("write then read", e0);

      e0 = err_cnt;
      cfg_write(CFG_CTRL, 0);
      for (int i = 0; i < DATA_ENTRIES; i++)
         push_req(write, 6'(8 + i), next_rand(), 3'(i));
      check_equal("req_ready_o", 0, req_ready_o);
      cfg_write(CFG_CTRL, 1);
      drain();
      check_equal("req_ready_o", 1, req_ready_o);
      check_reg("cfg_wr_cnt", CFG_WR_CNT, wr_pushed);
      end_test("write-data ring fill", e0);

      e0 = err_cnt;
      r0 = rsp_cnt;
      cfg_write(CFG_CTRL, 0);
      for (int i = 0; i < QUEUE_ENTRIES; i++)
         push_req(read, 6'(8 + i), '0, 3'(i));
      check_equal("req_ready_o", 0, req_ready_o);
      cfg_write(CFG_CTRL, 1);
      drain();
      check_equal("response count", QUEUE_ENTRIES, rsp_cnt - r0);
      end_test("command ring fill", e0);

      e0 = err_cnt;
      for (int i = 0; i < RAND_OPS; i++) begin
         r = next_rand();
         if (r[29:27] == 3'd0)
            cfg_write(CFG_CTRL, {31'd0, ~en_level});
         if (!req_ready_o && !en_level)
            cfg_write(CFG_CTRL, 1);  // Full while stalled
         a = r[16] ? r[5:0] : {3'd0, r[2:0]};  // Narrow range for address hits
         push_req(r_type'(r[20]), a, next_rand(), r[10:8]);
         repeat (r[1:0]) @(negedge clk);
      end
      cfg_write(CFG_CTRL, 1);
      drain();
      end_test("random mixed traffic", e0);

      e0 = err_cnt;
      check_reg("cfg_ctrl", CFG_CTRL, 1);
      check_reg("cfg_wr_cnt", CFG_WR_CNT, wr_pushed);
      check_reg("cfg_rd_cnt", CFG_RD_CNT, rd_pushed);
      cfg_write(CFG_WR_CNT, 32'hffff_ffff);  // Any write clears
      cfg_write(CFG_RD_CNT, 32'h0000_5a5a);
      check_reg("cfg_wr_cnt", CFG_WR_CNT, 0);
      check_reg("cfg_rd_cnt", CFG_RD_CNT, 0);
      end_test("counters", e0);

      $display("%0d tests run, %0d passed, %0d failed, %0d errors", test_cnt,
               test_cnt - fail_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== mem_req.f ====
design/mem_req_pkg.sv
design/req_queue_if.sv
design/mem_req_queue.sv
design/mem_engine.sv
design/mem_cfg_regs.sv
design/mem_req_top.sv
tests/mem_req_tb.sv
